//--- logic/mem_pipe_params.svh
`ifndef MEM_PIPE_PARAMS_SVH
`define MEM_PIPE_PARAMS_SVH

// Data and address width
`define MP_XLEN 32

// Page offset, 4 KiB pages
`define MP_PAGE_BITS 12

// Direct mapped, one word per line
`define MP_SETS 64
`define MP_IDX_BITS ($clog2(`MP_SETS))
`define MP_OFF_BITS 2

// Fully associative DTLB, 2, 4 or 8 entries
`define MP_TLB_ENTRIES 4

`endif

//--- logic/mem_pipe_pkg.sv
`include "mem_pipe_params.svh"

package mem_pipe_pkg;

  typedef logic [`MP_XLEN-1:0]                             word_t;
  typedef logic [`MP_XLEN-1:0]                             vaddr_t;
  typedef logic [`MP_XLEN-1:0]                             paddr_t;
  typedef logic [`MP_XLEN-`MP_PAGE_BITS-1:0]               vpn_t;
  typedef logic [`MP_XLEN-`MP_PAGE_BITS-1:0]               ppn_t;
  // Index sits inside the page offset
  typedef logic [`MP_XLEN-`MP_IDX_BITS-`MP_OFF_BITS-1:0]   ctag_t;
  typedef logic [`MP_IDX_BITS-1:0]                         cidx_t;
  typedef logic [4:0]                                      reg_addr_t;
  typedef logic [`MP_XLEN/8-1:0]                           sel_t;

  typedef enum logic [2:0] {LB, LH, LW, LBU, LHU, SB, SH, SW} mem_op_e;

  typedef enum logic [2:0] {
    EXC_NONE, EXC_LD_MISALIGN, EXC_ST_MISALIGN, EXC_LD_TLB_MISS, EXC_ST_TLB_MISS, EXC_ST_FAULT
  } mem_exc_e;

  typedef enum logic [1:0] {C_IDLE, C_BUS, C_DONE} cache_state_e;

  typedef struct packed {mem_op_e op; word_t rs1; word_t imm; word_t st_data; reg_addr_t rd;}
    mem_req_s;
  typedef struct packed {vpn_t vpn; ppn_t ppn; logic writable;} tlb_fill_s;
  typedef struct packed {
    logic v; mem_op_e op; paddr_t paddr; mem_exc_e exc; word_t st_data; reg_addr_t rd;
  } tlb_res_s;
  typedef struct packed {logic v; ctag_t tag; logic line_v; word_t data;} cache_look_s;
  typedef struct packed {logic we; paddr_t paddr; word_t data; sel_t sel; logic upd_line;}
    bus_cmd_s;
  typedef struct packed {logic cyc; logic stb; logic we; paddr_t adr; word_t dat; sel_t sel;}
    wb_m2s_s;
  typedef struct packed {word_t dat; logic ack;} wb_s2m_s;
  typedef struct packed {reg_addr_t rd; logic wb_v; word_t data; mem_exc_e exc;} mem_resp_s;

  function automatic logic op_is_store(mem_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(mem_op_e op);
    logic [1:0] size;
    unique case (op)
      LB, LBU, SB: size = 2'd0;
      LH, LHU, SH: size = 2'd1;
      default:     size = 2'd2;
    endcase
    return size;
  endfunction

endpackage

//--- logic/mem_dtlb.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_dtlb
  (input                              clk_i
   , input                            rst_n_i
   , input                            flush_i
   , input                            tlb_fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s  tlb_fill_i
   , input                            acc_i
   , input  mem_pipe_pkg::mem_req_s   req_i
   , input                            stall_i
   , output mem_pipe_pkg::tlb_res_s   tlb_res_o
   );

  import mem_pipe_pkg::*;

  localparam int ptr_w = $clog2(`MP_TLB_ENTRIES);

  logic [`MP_TLB_ENTRIES-1:0] ent_v_q;
  logic [`MP_TLB_ENTRIES-1:0] ent_w_q;
  vpn_t                       ent_vpn_q [`MP_TLB_ENTRIES];
  ppn_t                       ent_ppn_q [`MP_TLB_ENTRIES];
  logic [ptr_w-1:0]           rr_q;

  vaddr_t    eaddr;
  vpn_t      vpn;
  logic      is_store;
  logic      misaligned;
  logic      tlb_hit;
  ppn_t      hit_ppn;
  logic      hit_w;
  mem_exc_e  exc;

  logic      res_v_q;
  mem_op_e   op_q;
  paddr_t    paddr_q;
  mem_exc_e  exc_q;
  word_t     st_data_q;
  reg_addr_t rd_q;

  assign eaddr    = req_i.rs1 + req_i.imm;
  assign vpn      = eaddr[`MP_XLEN-1:`MP_PAGE_BITS];
  assign is_store = op_is_store(req_i.op);

  always_comb begin
    unique case (op_size(req_i.op))
      2'd1:    misaligned = eaddr[0];
      2'd2:    misaligned = |eaddr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // CAM match over all entries
  always_comb begin
    tlb_hit = 1'b0;
    hit_ppn = '0;
    hit_w   = 1'b0;
    for (int i = 0; i < `MP_TLB_ENTRIES; i++) begin
      if (ent_v_q[i] && (ent_vpn_q[i] == vpn)) begin
        tlb_hit = 1'b1;
        hit_ppn = ent_ppn_q[i];
        hit_w   = ent_w_q[i];
      end
    end
  end

  // Misalign beats miss beats write fault
  always_comb begin
    if (misaligned)
      exc = is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    else if (!tlb_hit)
      exc = is_store ? EXC_ST_TLB_MISS : EXC_LD_TLB_MISS;
    else if (is_store && !hit_w)
      exc = EXC_ST_FAULT;
    else
      exc = EXC_NONE;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ent_v_q <= '0;
      rr_q    <= '0;
      res_v_q <= 1'b0;
    end else begin
      if (flush_i)
        ent_v_q <= '0;
      // A fill in the flush cycle survives
      if (tlb_fill_v_i) begin
        ent_v_q[rr_q] <= 1'b1;
        rr_q          <= rr_q + 1'b1;
      end
      if (!stall_i)
        res_v_q <= acc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlb_fill_v_i) begin
      ent_vpn_q[rr_q] <= tlb_fill_i.vpn;
      ent_ppn_q[rr_q] <= tlb_fill_i.ppn;
      ent_w_q[rr_q]   <= tlb_fill_i.writable;
    end
    if (acc_i) begin
      op_q      <= req_i.op;
      paddr_q   <= {hit_ppn, eaddr[`MP_PAGE_BITS-1:0]};
      exc_q     <= exc;
      st_data_q <= req_i.st_data;
      rd_q      <= req_i.rd;
    end
  end

  assign tlb_res_o = '{v: res_v_q, op: op_q, paddr: paddr_q, exc: exc_q,
                       st_data: st_data_q, rd: rd_q};

endmodule

//--- logic/mem_dcache.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_dcache
  (input                                clk_i
   , input                              rst_n_i
   , input                              acc_i
   , input  mem_pipe_pkg::mem_req_s     req_i
   , input                              stall_i
   , input                              bus_req_v_i
   , input  mem_pipe_pkg::bus_cmd_s     bus_cmd_i
   , input  mem_pipe_pkg::wb_s2m_s      wb_i
   , output mem_pipe_pkg::cache_look_s  look_o
   , output logic                       bus_done_o
   , output mem_pipe_pkg::word_t        bus_rdata_o
   , output mem_pipe_pkg::wb_m2s_s      wb_o
   );

  import mem_pipe_pkg::*;

  logic [`MP_SETS-1:0] line_v_q;
  ctag_t               tag_q  [`MP_SETS];
  word_t               data_q [`MP_SETS];

  cache_state_e state_q;
  cache_state_e state_d;
  bus_cmd_s     cmd_q;
  word_t        rdata_q;

  vaddr_t eaddr;
  cidx_t  req_idx;
  cidx_t  wr_idx;
  ctag_t  wr_tag;
  word_t  wr_word;
  logic   arr_we;

  logic   look_v_q;
  cidx_t  look_idx_q;
  ctag_t  look_tag_q;
  logic   look_line_v_q;
  word_t  look_data_q;
  cidx_t  look_idx_d;
  ctag_t  look_tag_d;
  logic   look_line_v_d;
  word_t  look_data_d;

  // Virtual index, bits below the page offset
  assign eaddr   = req_i.rs1 + req_i.imm;
  assign req_idx = eaddr[`MP_IDX_BITS+`MP_OFF_BITS-1:`MP_OFF_BITS];

  assign wr_idx = cmd_q.paddr[`MP_IDX_BITS+`MP_OFF_BITS-1:`MP_OFF_BITS];
  assign wr_tag = cmd_q.paddr[`MP_XLEN-1:`MP_IDX_BITS+`MP_OFF_BITS];
  // Reads fill, writes touch the line only on a hit
  assign arr_we = (state_q == C_BUS) && wb_i.ack && (!cmd_q.we || cmd_q.upd_line);

  always_comb begin
    for (int b = 0; b < `MP_XLEN/8; b++) begin
      if (!cmd_q.we)
        wr_word[8*b +: 8] = wb_i.dat[8*b +: 8];
      else if (cmd_q.sel[b])
        wr_word[8*b +: 8] = cmd_q.data[8*b +: 8];
      else
        wr_word[8*b +: 8] = data_q[wr_idx][8*b +: 8];
    end
  end

  always_comb begin
    look_idx_d    = look_idx_q;
    look_tag_d    = look_tag_q;
    look_line_v_d = look_line_v_q;
    look_data_d   = look_data_q;
    if (acc_i) begin
      look_idx_d    = req_idx;
      look_tag_d    = tag_q[req_idx];
      look_line_v_d = line_v_q[req_idx];
      look_data_d   = data_q[req_idx];
    end
    // Same-cycle array write wins over the stored copy
    if (arr_we && (wr_idx == look_idx_d)) begin
      look_tag_d    = wr_tag;
      look_line_v_d = 1'b1;
      look_data_d   = wr_word;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      C_IDLE:  if (bus_req_v_i) state_d = C_BUS;
      C_BUS:   if (wb_i.ack) state_d = C_DONE;
      default: state_d = C_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= C_IDLE;
      line_v_q <= '0;
      look_v_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (arr_we)
        line_v_q[wr_idx] <= 1'b1;
      if (!stall_i)
        look_v_q <= acc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arr_we) begin
      tag_q[wr_idx]  <= wr_tag;
      data_q[wr_idx] <= wr_word;
    end
    if ((state_q == C_IDLE) && bus_req_v_i)
      cmd_q <= bus_cmd_i;
    if ((state_q == C_BUS) && wb_i.ack)
      rdata_q <= wb_i.dat;
    look_idx_q    <= look_idx_d;
    look_tag_q    <= look_tag_d;
    look_line_v_q <= look_line_v_d;
    look_data_q   <= look_data_d;
  end

  assign look_o = '{v: look_v_q, tag: look_tag_q, line_v: look_line_v_q, data: look_data_q};

  assign bus_done_o  = (state_q == C_DONE);
  assign bus_rdata_o = rdata_q;

  // Single classic transfer, fields held from cmd_q
  assign wb_o = '{cyc: (state_q == C_BUS), stb: (state_q == C_BUS), we: cmd_q.we,
                  adr: {cmd_q.paddr[`MP_XLEN-1:`MP_OFF_BITS], {`MP_OFF_BITS{1'b0}}},
                  dat: cmd_q.data, sel: cmd_q.sel};

endmodule

//--- logic/mem_result_stage.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_result_stage
  (input                                clk_i
   , input                              rst_n_i
   , input  mem_pipe_pkg::tlb_res_s     tlb_res_i
   , input  mem_pipe_pkg::cache_look_s  look_i
   , input                              bus_done_i
   , input  mem_pipe_pkg::word_t        bus_rdata_i
   , output logic                       stall_o
   , output logic                       bus_req_v_o
   , output mem_pipe_pkg::bus_cmd_s     bus_cmd_o
   , output logic                       resp_v_o
   , output mem_pipe_pkg::mem_resp_s    resp_o
   );

  import mem_pipe_pkg::*;

  logic       is_store;
  logic       no_exc;
  logic       hit;
  logic       need_bus;
  logic       fire;
  logic       ld_ok;
  logic [1:0] boff;
  word_t      raw;
  word_t      shifted;
  word_t      ld_data;
  sel_t       sel;
  logic       resp_v_q;
  mem_resp_s  resp_q;

  assign is_store = op_is_store(tlb_res_i.op);
  assign no_exc   = (tlb_res_i.exc == EXC_NONE);
  assign ld_ok    = !is_store && no_exc;
  assign hit      = look_i.v && look_i.line_v &&
                    (look_i.tag == tlb_res_i.paddr[`MP_XLEN-1:`MP_IDX_BITS+`MP_OFF_BITS]);

  // Load misses and all stores wait for the bus
  assign need_bus    = tlb_res_i.v && no_exc && (is_store || !hit);
  assign stall_o     = need_bus && !bus_done_i;
  assign bus_req_v_o = need_bus;
  assign fire        = tlb_res_i.v && (!need_bus || bus_done_i);

  assign boff    = tlb_res_i.paddr[1:0];
  assign raw     = bus_done_i ? bus_rdata_i : look_i.data;
  assign shifted = raw >> {boff, 3'b000};

  always_comb begin
    unique case (tlb_res_i.op)
      LB:      ld_data = {{(`MP_XLEN-8){shifted[7]}}, shifted[7:0]};
      LBU:     ld_data = {{(`MP_XLEN-8){1'b0}}, shifted[7:0]};
      LH:      ld_data = {{(`MP_XLEN-16){shifted[15]}}, shifted[15:0]};
      LHU:     ld_data = {{(`MP_XLEN-16){1'b0}}, shifted[15:0]};
      default: ld_data = shifted;
    endcase
  end

  // Loads fetch the whole word
  always_comb begin
    unique case (op_size(tlb_res_i.op))
      2'd0:    sel = sel_t'(4'b0001) << boff;
      2'd1:    sel = sel_t'(4'b0011) << boff;
      default: sel = '1;
    endcase
    if (!is_store)
      sel = '1;
  end

  assign bus_cmd_o = '{we: is_store, paddr: tlb_res_i.paddr,
                       data: tlb_res_i.st_data << {boff, 3'b000}, sel: sel,
                       upd_line: is_store && hit};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)
      resp_v_q <= 1'b0;
    else
      resp_v_q <= fire;
  end

  always_ff @(posedge clk_i) begin
    if (fire)
      resp_q <= '{rd: tlb_res_i.rd, wb_v: ld_ok, data: ld_ok ? ld_data : '0,
                  exc: tlb_res_i.exc};
  end

  assign resp_v_o = resp_v_q;
  assign resp_o   = resp_q;

endmodule

//--- logic/mem_pipe.sv
`timescale 1ns/1ps

module mem_pipe
  (input                               clk_i
   , input                             rst_n_i
   , input                             req_v_i
   , output logic                      req_ready_o
   , input  mem_pipe_pkg::mem_req_s    req_i
   , input                             flush_i
   , input                             tlb_fill_v_i
   , input  mem_pipe_pkg::tlb_fill_s   tlb_fill_i
   , output logic                      resp_v_o
   , output mem_pipe_pkg::mem_resp_s   resp_o
   , output mem_pipe_pkg::wb_m2s_s     wb_o
   , input  mem_pipe_pkg::wb_s2m_s     wb_i
   );

  import mem_pipe_pkg::*;

  logic        stall;
  logic        acc;
  tlb_res_s    tlb_res;
  cache_look_s look;
  logic        bus_req_v;
  bus_cmd_s    bus_cmd;
  logic        bus_done;
  word_t       bus_rdata;

  assign req_ready_o = !stall;
  assign acc         = req_v_i && !stall;

  mem_dtlb
   dtlb
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.flush_i(flush_i)
     ,.tlb_fill_v_i(tlb_fill_v_i)
     ,.tlb_fill_i(tlb_fill_i)
     ,.acc_i(acc)
     ,.req_i(req_i)
     ,.stall_i(stall)
     ,.tlb_res_o(tlb_res)
     );

  mem_dcache
   dcache
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.acc_i(acc)
     ,.req_i(req_i)
     ,.stall_i(stall)
     ,.bus_req_v_i(bus_req_v)
     ,.bus_cmd_i(bus_cmd)
     ,.wb_i(wb_i)
     ,.look_o(look)
     ,.bus_done_o(bus_done)
     ,.bus_rdata_o(bus_rdata)
     ,.wb_o(wb_o)
     );

  mem_result_stage
   result
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.tlb_res_i(tlb_res)
     ,.look_i(look)
     ,.bus_done_i(bus_done)
     ,.bus_rdata_i(bus_rdata)
     ,.stall_o(stall)
     ,.bus_req_v_o(bus_req_v)
     ,.bus_cmd_o(bus_cmd)
     ,.resp_v_o(resp_v_o)
     ,.resp_o(resp_o)
     );

endmodule

//--- verif/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model
  (input                             clk_i
   , input                           rst_n_i
   , input  mem_pipe_pkg::wb_m2s_s   wb_i
   , output mem_pipe_pkg::wb_s2m_s   wb_o
   );

  import mem_pipe_pkg::*;

  word_t       mem [1024];
  paddr_t      wr_log [$];
  int unsigned lcg_state = 75311;
  logic        busy_q;
  logic [1:0]  wait_q;
  logic [1:0]  wait_left;
  logic        ack_q;
  word_t       dat_q;

  function logic [1:0] draw_wait();
    lcg_state = lcg_state * 1103515245 + 12345;
    return lcg_state[17:16];
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++)
      mem[i] = i ^ 32'hA5A50000;
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= '0;
    end else begin
      ack_q <= 1'b0;
      if (wb_i.cyc && wb_i.stb && !ack_q) begin
        // Zero wait states acks on the first edge
        if (busy_q)
          wait_left = wait_q;
        else
          wait_left = draw_wait();
        if (wait_left != 0) begin
          busy_q <= 1'b1;
          wait_q <= wait_left - 1'b1;
        end else begin
          ack_q  <= 1'b1;
          busy_q <= 1'b0;
          dat_q  <= mem[wb_i.adr[11:2]];
          if (wb_i.we) begin
            for (int b = 0; b < 4; b++)
              if (wb_i.sel[b])
                mem[wb_i.adr[11:2]][8*b +: 8] <= wb_i.dat[8*b +: 8];
            wr_log.push_back(wb_i.adr);
          end
        end
      end
    end
  end

  assign wb_o = '{dat: dat_q, ack: ack_q};

endmodule

//--- verif/mem_pipe_tb.sv
`timescale 1ns/1ps
`include "mem_pipe_params.svh"

module mem_pipe_tb;

  import mem_pipe_pkg::*;

  localparam int CLK_NS     = 8;
  localparam int MAX_OPS    = 600;
  localparam int CYC_PER_OP = 40;

  logic      clk;
  logic      rst_n;
  logic      req_v;
  logic      req_ready;
  logic      flush;
  logic      fill_v;
  logic      resp_v;
  mem_req_s  req;
  tlb_fill_s fill;
  mem_resp_s resp;
  wb_m2s_s   wb_m2s;
  wb_s2m_s   wb_s2m;

  word_t                      shadow [1024];
  logic [`MP_SETS-1:0]        line_v;
  ctag_t                      line_tag [`MP_SETS];
  logic [`MP_TLB_ENTRIES-1:0] map_v;
  vpn_t                       map_vpn [`MP_TLB_ENTRIES];
  ppn_t                       map_ppn [`MP_TLB_ENTRIES];
  logic                       map_w [`MP_TLB_ENTRIES];
  int                         map_rr;

  mem_resp_s exp_q [$];
  logic      exp_bus_q [$];
  int        exp_acc_q [$];
  paddr_t    wadr_q [$];
  word_t     wdat_q [$];
  sel_t      wsel_q [$];

  int          cycle = 0;
  int          last_ack = 0;
  int          xfers = 0;
  int          exp_xfers = 0;
  int          exp_writes = 0;
  int          val_errs = 0;
  int          other_errs = 0;
  int unsigned seed = 75311;
  logic        held = 1'b0;
  wb_m2s_s     prev_m2s;

  mem_pipe UUT (.clk_i(clk), .rst_n_i(rst_n), .req_v_i(req_v), .req_ready_o(req_ready),
                .req_i(req), .flush_i(flush), .tlb_fill_v_i(fill_v), .tlb_fill_i(fill),
                .resp_v_o(resp_v), .resp_o(resp), .wb_o(wb_m2s), .wb_i(wb_s2m));

  wb_mem_model mem_model (.clk_i(clk), .rst_n_i(rst_n), .wb_i(wb_m2s), .wb_o(wb_s2m));

  initial begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  initial begin
    repeat (MAX_OPS * CYC_PER_OP) @(posedge clk);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Verification failed");
    $finish;
  end

  function int unsigned rand_next();
    seed = seed * 1103515245 + 12345;
    return seed >> 8;
  endfunction

  function automatic int size_of(mem_op_e op);
    if (op == LW || op == SW)
      return 4;
    if (op == LH || op == LHU || op == SH)
      return 2;
    return 1;
  endfunction

  task automatic check_val(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      val_errs++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      other_errs++;
      $display("Check failed: %s", what);
    end
  endtask

  // Reference model, evaluated in acceptance order
  task automatic predict(input mem_req_s r, input int acc);
    vaddr_t    ea;
    paddr_t    pa;
    ppn_t      ppn;
    word_t     sh;
    word_t     d;
    sel_t      sel;
    logic      st;
    logic      found;
    logic      wr;
    logic      hit;
    logic      need;
    int        sz;
    cidx_t     idx;
    mem_resp_s e;
    ea    = r.rs1 + r.imm;
    sz    = size_of(r.op);
    st    = (r.op == SB || r.op == SH || r.op == SW);
    found = 1'b0;
    wr    = 1'b0;
    ppn   = '0;
    for (int k = 0; k < `MP_TLB_ENTRIES; k++) begin
      if (map_v[k] && map_vpn[k] == ea[31:12]) begin
        found = 1'b1;
        ppn   = map_ppn[k];
        wr    = map_w[k];
      end
    end
    pa  = {ppn, ea[11:0]};
    idx = pa[7:2];
    hit = line_v[idx] && (line_tag[idx] == pa[31:8]);
    e   = '{rd: r.rd, wb_v: 1'b0, data: '0, exc: EXC_NONE};
    if ((ea & (sz - 1)) != 0)
      e.exc = st ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    else if (!found)
      e.exc = st ? EXC_ST_TLB_MISS : EXC_LD_TLB_MISS;
    else if (st && !wr)
      e.exc = EXC_ST_FAULT;
    need = (e.exc == EXC_NONE) && (st || !hit);
    if (e.exc == EXC_NONE && !st) begin
      sh = shadow[pa[11:2]] >> {pa[1:0], 3'b000};
      case (r.op)
        LB:      e.data = {{24{sh[7]}}, sh[7:0]};
        LBU:     e.data = {24'h0, sh[7:0]};
        LH:      e.data = {{16{sh[15]}}, sh[15:0]};
        LHU:     e.data = {16'h0, sh[15:0]};
        default: e.data = sh;
      endcase
      e.wb_v        = 1'b1;
      line_v[idx]   = 1'b1;
      line_tag[idx] = pa[31:8];
    end
    if (need && st) begin
      sel = (sz == 1) ? 4'b0001 : (sz == 2) ? 4'b0011 : 4'b1111;
      sel = sel << pa[1:0];
      d   = r.st_data << {pa[1:0], 3'b000};
      for (int b = 0; b < 4; b++)
        if (sel[b])
          shadow[pa[11:2]][8*b +: 8] = d[8*b +: 8];
      wadr_q.push_back({pa[31:2], 2'b00});
      wdat_q.push_back(d);
      wsel_q.push_back(sel);
      exp_writes++;
    end
    if (need)
      exp_xfers++;
    exp_q.push_back(e);
    exp_bus_q.push_back(need);
    exp_acc_q.push_back(acc);
  endtask

  // Returns the number of the accepting edge
  task automatic access(input mem_op_e op, input word_t ea, input word_t st,
                        input reg_addr_t rd, output int acc);
    mem_req_s    r;
    int unsigned x;
    word_t       imm;
    x   = rand_next();
    imm = {{20{x[11]}}, x[11:0]};
    r   = '{op: op, rs1: ea - imm, imm: imm, st_data: st, rd: rd};
    @(posedge clk);
    req_v <= 1'b1;
    req   <= r;
    @(negedge clk);
    while (!req_ready)
      @(negedge clk);
    acc = cycle + 1;
    predict(r, acc);
  endtask

  task automatic idle();
    @(posedge clk);
    req_v <= 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  task automatic map(input vpn_t vpn, input ppn_t ppn, input logic w);
    @(posedge clk);
    fill_v <= 1'b1;
    fill   <= '{vpn: vpn, ppn: ppn, writable: w};
    @(posedge clk);
    fill_v <= 1'b0;
    map_v[map_rr]   = 1'b1;
    map_vpn[map_rr] = vpn;
    map_ppn[map_rr] = ppn;
    map_w[map_rr]   = w;
    map_rr          = (map_rr + 1) % `MP_TLB_ENTRIES;
  endtask

  // Response and bus monitor
  always @(negedge clk) begin : monitor
    mem_resp_s e;
    logic      bus;
    int        acc;
    word_t     mask;
    if (rst_n) begin
      check_true(!wb_m2s.stb || wb_m2s.cyc, "Wishbone stb high without cyc");
      if (held)
        check_true(wb_m2s == prev_m2s, "Wishbone fields changed before ack");
      held     = wb_m2s.cyc && wb_m2s.stb && !wb_s2m.ack;
      prev_m2s = wb_m2s;
      if (wb_m2s.cyc && wb_s2m.ack) begin
        xfers++;
        last_ack = cycle;
        if (wb_m2s.we && wadr_q.size() == 0) begin
          check_true(1'b0, "unexpected Wishbone write");
        end else if (wb_m2s.we) begin
          for (int b = 0; b < 4; b++)
            mask[8*b +: 8] = {8{wsel_q[0][b]}};
          check_val("wb_o.adr", wb_m2s.adr, wadr_q.pop_front());
          check_val("wb_o.sel", wb_m2s.sel, wsel_q.pop_front());
          check_val("wb_o.dat", wb_m2s.dat & mask, wdat_q.pop_front() & mask);
        end
      end
      if (resp_v && exp_q.size() == 0) begin
        check_true(1'b0, "response with no request outstanding");
      end else if (resp_v) begin
        e   = exp_q.pop_front();
        bus = exp_bus_q.pop_front();
        acc = exp_acc_q.pop_front();
        check_val("resp_o.rd", resp.rd, e.rd);
        check_val("resp_o.wb_v", resp.wb_v, e.wb_v);
        check_val("resp_o.data", resp.data, e.data);
        check_val("resp_o.exc", resp.exc, e.exc);
        if (bus)
          check_true(cycle == last_ack + 2, "bus response not right after ack");
        else
          check_true(cycle == acc + 1, "hit or exception response at wrong cycle");
      end
    end
  end

  initial begin
    int          acc;
    int          prev;
    int          sz;
    int unsigned r;
    mem_op_e     op;
    logic [8:0]  off;
    word_t       ea;
    rst_n  = 1'b0;
    req_v  = 1'b0;
    req    = '0;
    flush  = 1'b0;
    fill_v = 1'b0;
    fill   = '0;
    for (int i = 0; i < 1024; i++)
      shadow[i] = i ^ 32'hA5A50000;
    line_v = '0;
    map_v  = '0;
    map_rr = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Both virtual pages alias physical page 0
    map(20'h00010, 20'h00000, 1'b1);
    map(20'h00020, 20'h00000, 1'b0);

    for (int i = 0; i < 400; i++) begin
      r   = rand_next();
      op  = mem_op_e'(r[2:0]);
      sz  = size_of(op);
      off = r[16:8];
      if (sz > 1)
        off[0] = 1'b0;
      if (sz > 2)
        off[1] = 1'b0;
      if (r[20] && op inside {LB, LH, LW, LBU, LHU})
        ea = {20'h00020, 3'b000, off};
      else
        ea = {20'h00010, 3'b000, off};
      access(op, ea, rand_next(), i[4:0], acc);
    end
    idle();

    // Merged bytes, uncached line then cached line
    access(SB, 32'h00010301, 32'h5A, 5'd1, acc);
    access(LW, 32'h00010300, 32'h0, 5'd2, acc);
    access(SH, 32'h00010302, 32'hBEEF, 5'd3, acc);
    access(LW, 32'h00010300, 32'h0, 5'd4, acc);
    access(LB, 32'h00010302, 32'h0, 5'd5, acc);

    access(LH, 32'h00010001, 32'h0, 5'd6, acc);
    access(LW, 32'h00010002, 32'h0, 5'd7, acc);
    access(LHU, 32'h00010003, 32'h0, 5'd8, acc);
    access(SH, 32'h00010005, 32'h1234, 5'd9, acc);
    access(SW, 32'h00010006, 32'h1234, 5'd10, acc);

    access(LW, 32'h00030000, 32'h0, 5'd11, acc);
    access(SW, 32'h00030000, 32'h77, 5'd12, acc);
    access(SB, 32'h00020010, 32'h77, 5'd13, acc);
    access(LW, 32'h00020010, 32'h0, 5'd14, acc);
    idle();

    access(LW, 32'h00010040, 32'h0, 5'd15, acc);
    idle();
    for (int i = 0; i < 8; i++) begin
      access(LW, 32'h00010040, 32'h0, i[4:0], acc);
      if (i > 0)
        check_true(acc == prev + 1, "back to back hit not accepted every cycle");
      prev = acc;
    end
    idle();

    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    map_v = '0;
    access(LW, 32'h00010040, 32'h0, 5'd20, acc);
    access(SW, 32'h00010040, 32'h99, 5'd21, acc);
    idle();

    repeat (4) @(posedge clk);
    check_true(xfers == exp_xfers, "transfer count differs from misses plus stores");
    check_true(mem_model.wr_log.size() == exp_writes, "memory write log has wrong size");
    $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs + other_errs == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/mem_pipe_pkg.sv
logic/mem_dtlb.sv
logic/mem_dcache.sv
logic/mem_result_stage.sv
logic/mem_pipe.sv
verif/wb_mem_model.sv
verif/mem_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mem_pipe_tb --Mdir obj_dir -o mem_pipe_sim \
  -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mem_pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Verification passed$"; then
  exit 0
fi
exit 1
